// ==== uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    localparam int CLKS_PER_BAUD = 16;  // kept short for simulation
    localparam int FRAME_BITS = 11;     // start, 8 data, parity, stop

    typedef logic [7:0] uart_byte_t;
    typedef logic [$clog2(CLKS_PER_BAUD)-1:0] baud_cnt_t;
    typedef logic [2:0] bit_idx_t;

    // counter compare points
    localparam baud_cnt_t BAUD_LAST = baud_cnt_t'(CLKS_PER_BAUD - 1);
    localparam baud_cnt_t BAUD_MID = baud_cnt_t'(CLKS_PER_BAUD / 2);

    localparam bit_idx_t LAST_BIT = 3'd7;  // msb of the data byte

endpackage

`default_nettype wire

// ==== link_pkg.sv ====
`default_nettype none

package link_pkg;

    localparam int NUM_CHAN = 2;

    typedef logic [$clog2(NUM_CHAN)-1:0] chan_id_t;

    // one byte offered over req/ack with data held while req is high
    typedef struct packed {
        logic                 req;
        uart_pkg::uart_byte_t data;
    } tx_req_t;

    // valid pulses once per received frame
    typedef struct packed {
        logic                 valid;
        uart_pkg::uart_byte_t data;
        logic                 parity_err;
        logic                 framing_err;
    } rx_result_t;

endpackage

`default_nettype wire

// ==== tx_arbiter.sv ====
`default_nettype none

module tx_arbiter (
    input  wire                                             clk,
    input  wire                                             nRst,
    input  wire link_pkg::tx_req_t [link_pkg::NUM_CHAN-1:0] client_req,
    output logic [link_pkg::NUM_CHAN-1:0]                   client_ack,
    output link_pkg::tx_req_t                               tx_req,
    input  wire                                             tx_ack
);
    import link_pkg::*;

    typedef enum logic [1:0] {
        FREE,
        REQ,
        HOLD
    } arb_state_t;

    arb_state_t state;
    chan_id_t   grant;    // also serves as last grant
    chan_id_t   winner;
    logic       any_req;

    always_comb begin
        any_req = 1'b0;
        for (int i = 0; i < NUM_CHAN; i++) begin
            any_req = any_req | client_req[i].req;
        end
    end

    // round robin between the two channels
    always_comb begin
        if (client_req[0].req && client_req[1].req) begin
            winner = ~grant;  // tie goes to the one not served last
        end else if (client_req[1].req) begin
            winner = chan_id_t'(1);
        end else begin
            winner = chan_id_t'(0);
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state <= FREE;
            grant <= chan_id_t'(NUM_CHAN - 1);  // ch0 wins the first tie
        end else begin
            case (state)
                FREE: begin
                    if (any_req) begin
                        grant <= winner;
                        state <= REQ;
                    end
                end
                REQ: begin
                    if (tx_ack && !client_req[grant].req) begin
                        state <= HOLD;  // client side done
                    end
                end
                HOLD: begin
                    if (!tx_ack) begin
                        state <= FREE;  // tx side back to zero
                    end
                end
                default: state <= FREE;
            endcase
        end
    end

    always_comb begin
        tx_req.req  = (state == REQ) && client_req[grant].req;
        tx_req.data = client_req[grant].data;
    end

    always_comb begin
        client_ack        = '0;
        client_ack[grant] = tx_ack;  // steer ack to the granted client only
    end

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
`default_nettype none

module uart_tx (
    input  wire               clk,
    input  wire               nRst,
    input  wire link_pkg::tx_req_t tx_req,
    output logic              tx_ack,
    output logic              tx_serial,
    output logic              tx_busy
);
    import uart_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        START,
        DATA,
        PARITY,
        STOP
    } tx_state_t;

    tx_state_t  state;
    baud_cnt_t  baud_cnt;
    bit_idx_t   bit_idx;
    uart_byte_t shift_q;
    logic       parity_q;   // running xor of sent bits
    logic       accept;
    logic       baud_done;

    assign accept    = (state == IDLE) && tx_req.req && !tx_ack;
    assign baud_done = (baud_cnt == BAUD_LAST);

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            tx_ack <= 1'b0;
        end else if (accept) begin
            tx_ack <= 1'b1;
        end else if (!tx_req.req) begin
            tx_ack <= 1'b0;  // return to zero
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state    <= IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
        end else begin
            if (state == IDLE || baud_done) begin
                baud_cnt <= '0;
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
            case (state)
                IDLE: begin
                    bit_idx <= '0;
                    if (accept) state <= START;
                end
                START: if (baud_done) state <= DATA;
                DATA: begin
                    if (baud_done) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == LAST_BIT) state <= PARITY;
                    end
                end
                PARITY: if (baud_done) state <= STOP;
                STOP: if (baud_done) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            shift_q  <= tx_req.data;
            parity_q <= 1'b0;
        end else if (state == DATA && baud_done) begin
            shift_q  <= {1'b0, shift_q[7:1]};   // lsb first
            parity_q <= parity_q ^ shift_q[0];
        end
    end

    always_comb begin
        case (state)
            START:   tx_serial = 1'b0;
            DATA:    tx_serial = shift_q[0];
            PARITY:  tx_serial = parity_q;  // makes total ones even
            default: tx_serial = 1'b1;      // idle and stop
        endcase
    end

    assign tx_busy = (state != IDLE);

endmodule

`default_nettype wire

// ==== uart_rx.sv ====
`default_nettype none

module uart_rx (
    input  wire                  clk,
    input  wire                  nRst,
    input  wire                  rx_serial,
    output link_pkg::rx_result_t rx_result
);
    import uart_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        START,
        DATA,
        PARITY,
        STOP
    } rx_state_t;

    rx_state_t  state;
    logic [1:0] sync_q;
    logic       rx_s;
    logic       rx_prev;
    baud_cnt_t  baud_cnt;
    bit_idx_t   bit_idx;
    logic       sample;       // mid of a data, parity or stop bit
    uart_byte_t data_q;
    logic       parity_err_q;
    logic       framing_err_q;
    logic       valid_q;

    assign rx_s   = sync_q[1];
    assign sample = (baud_cnt == BAUD_LAST);

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            sync_q  <= 2'b11;  // line idles high
            rx_prev <= 1'b1;
        end else begin
            sync_q  <= {sync_q[0], rx_serial};
            rx_prev <= rx_s;
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state    <= IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            valid_q  <= 1'b0;
        end else begin
            valid_q  <= 1'b0;
            baud_cnt <= baud_cnt + 1'b1;
            case (state)
                IDLE: begin
                    baud_cnt <= '0;
                    bit_idx  <= '0;
                    if (rx_prev && !rx_s) state <= START;  // falling edge
                end
                START: begin
                    if (baud_cnt == BAUD_MID) begin
                        baud_cnt <= '0;
                        state    <= rx_s ? IDLE : DATA;    // high here is a glitch
                    end
                end
                DATA: begin
                    if (sample) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == LAST_BIT) state <= PARITY;
                    end
                end
                PARITY: begin
                    if (sample) begin
                        baud_cnt <= '0;
                        state    <= STOP;
                    end
                end
                STOP: begin
                    if (sample) begin
                        valid_q <= 1'b1;
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sample) begin
            case (state)
                DATA:    data_q        <= {rx_s, data_q[7:1]};
                PARITY:  parity_err_q  <= ^data_q ^ rx_s;  // odd count of ones
                STOP:    framing_err_q <= !rx_s;
                default: ;
            endcase
        end
    end

    always_comb begin
        rx_result.valid       = valid_q;
        rx_result.data        = data_q;
        rx_result.parity_err  = parity_err_q;
        rx_result.framing_err = framing_err_q;
    end

endmodule

`default_nettype wire

// ==== uart_link.sv ====
`default_nettype none

module uart_link (
    input  wire                                             clk,
    input  wire                                             nRst,
    input  wire link_pkg::tx_req_t [link_pkg::NUM_CHAN-1:0] client_req,
    input  wire                                             rx_serial,
    output logic [link_pkg::NUM_CHAN-1:0]                   client_ack,
    output logic                                            tx_serial,
    output link_pkg::rx_result_t                            rx_result,
    output logic                                            tx_busy
);
    import link_pkg::*;

    tx_req_t tx_req;   // arbiter to transmitter
    logic    tx_ack;

    tx_arbiter i_tx_arbiter (
        .clk        (clk),
        .nRst       (nRst),
        .client_req (client_req),
        .client_ack (client_ack),
        .tx_req     (tx_req),
        .tx_ack     (tx_ack)
    );

    uart_tx i_uart_tx (
        .clk       (clk),
        .nRst      (nRst),
        .tx_req    (tx_req),
        .tx_ack    (tx_ack),
        .tx_serial (tx_serial),
        .tx_busy   (tx_busy)
    );

    // rx line comes from outside and may face a remote transmitter
    uart_rx i_uart_rx (
        .clk       (clk),
        .nRst      (nRst),
        .rx_serial (rx_serial),
        .rx_result (rx_result)
    );

endmodule

`default_nettype wire

// ==== uart_link_props.sv ====
`default_nettype none

module uart_link_props (
    input wire                                             clk,
    input wire                                             nRst,
    input wire link_pkg::tx_req_t [link_pkg::NUM_CHAN-1:0] client_req,
    input wire [link_pkg::NUM_CHAN-1:0]                    client_ack,
    input wire                                             tx_serial,
    input wire                                             tx_busy
);
    import link_pkg::*;

    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
        assert property (@(posedge clk) disable iff (!nRst)
            $fell(client_req[i].req) |-> $past(client_ack[i]))  // req held until ack
            else $error("client %0d dropped req before its ack rose", i);
    end

    assert property (@(posedge clk) disable iff (!nRst) !tx_busy |-> tx_serial)
        else $error("tx line low while the transmitter is idle");

    assert property (@(posedge clk) disable iff (!nRst) $onehot0(client_ack))
        else $error("more than one client ack high");

endmodule

bind uart_link uart_link_props i_uart_link_props (
    .clk        (clk),
    .nRst       (nRst),
    .client_req (client_req),
    .client_ack (client_ack),
    .tx_serial  (tx_serial),
    .tx_busy    (tx_busy)
);

`default_nettype wire

// ==== uart_link_tb.sv ====
`default_nettype none

module uart_link_tb;
    import uart_pkg::*;
    import link_pkg::*;

    localparam int FRAME_CYCLES = FRAME_BITS * CLKS_PER_BAUD;
    localparam int PARITY_START = 9 * CLKS_PER_BAUD;   // parity bit window on the line
    localparam int PARITY_END = 10 * CLKS_PER_BAUD;

    typedef struct packed {
        logic [1:0] mask;
        uart_byte_t b0;
        uart_byte_t b1;
        logic       corrupt;
    } vec_t;

    logic                        clk;
    logic                        nRst;
    tx_req_t [NUM_CHAN-1:0]      client_req;
    logic                        rx_serial = 1'b1;
    logic [NUM_CHAN-1:0]         client_ack;
    logic                        tx_serial;
    rx_result_t                  rx_result;
    logic                        tx_busy;

    vec_t       vecs[$];
    logic [8:0] exp_q[$];           // {parity_err, data}
    integer     seed = 32'hc45f_bcea;
    int         cyc = 0;
    int         timeout_limit = 200;
    int         line_pos = -1;      // cycles into the current frame
    logic       corrupt_on = 1'b0;
    chan_id_t   last_grant = chan_id_t'(1);

    uart_link i_uart_link (
        .clk        (clk),
        .nRst       (nRst),
        .client_req (client_req),
        .rx_serial  (rx_serial),
        .client_ack (client_ack),
        .tx_serial  (tx_serial),
        .rx_result  (rx_result),
        .tx_busy    (tx_busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic uart_byte_t byte_for(input vec_t v, input chan_id_t ch);
        return ch ? v.b1 : v.b0;
    endfunction

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc > timeout_limit) begin
            report_failure($sformatf("timeout: run did not finish within %0d cycles",
                                     timeout_limit));
        end
    end

    // loopback with the parity bit flipped on corrupted lines
    always @(posedge clk) begin
        int pos;
        if (!nRst) begin
            line_pos  <= -1;
            rx_serial <= 1'b1;
        end else begin
            pos = (line_pos >= 0) ? line_pos + 1 : -1;
            if (pos >= FRAME_CYCLES) pos = -1;
            if (pos < 0 && !tx_serial) pos = 0;   // start bit
            rx_serial <= tx_serial ^ (corrupt_on && pos >= PARITY_START && pos < PARITY_END);
            line_pos  <= pos;
        end
    end

    task automatic check_result();
        logic [8:0] exp;
        assert (exp_q.size() != 0) else report_failure("received a frame that was never sent");
        exp = exp_q.pop_front();
        assert (rx_result.data == exp[7:0])
            else report_failure($sformatf("FAILED rx_result.data: got 0x%02h expected 0x%02h",
                                          rx_result.data, exp[7:0]));
        assert (rx_result.parity_err == exp[8])
            else report_failure($sformatf("FAILED rx_result.parity_err: got 0x%0h expected 0x%0h",
                                          rx_result.parity_err, exp[8]));
        assert (!rx_result.framing_err)
            else report_failure($sformatf("FAILED rx_result.framing_err: got 0x%0h expected 0x0",
                                          rx_result.framing_err));
    endtask

    always @(negedge clk) begin
        if (nRst && rx_result.valid) begin
            check_result();
        end
    end

    task automatic run_line(input vec_t v);
        chan_id_t            first;
        logic [NUM_CHAN-1:0] pending;
        logic                saw_idle;
        logic                prev_line;
        int                  n_acked;
        int                  req_cyc;
        int                  gap;
        while (tx_busy) @(posedge clk);
        gap = 1 + ($unsigned($random(seed)) % 6);
        repeat (gap) @(posedge clk);
        if (v.mask == 2'b11) first = ~last_grant;   // tie goes to the one not served last
        else if (v.mask == 2'b10) first = chan_id_t'(1);
        else first = chan_id_t'(0);
        exp_q.push_back({v.corrupt, byte_for(v, first)});
        if (v.mask == 2'b11) exp_q.push_back({v.corrupt, byte_for(v, ~first)});
        corrupt_on <= v.corrupt;
        for (int i = 0; i < NUM_CHAN; i++) begin
            if (v.mask[i]) begin
                client_req[i].req  <= 1'b1;
                client_req[i].data <= byte_for(v, chan_id_t'(i));
            end
        end
        req_cyc   = cyc;
        prev_line = tx_serial;
        pending   = v.mask;
        saw_idle  = 1'b0;
        n_acked   = 0;
        while (pending != '0) begin
            @(posedge clk);
            for (int i = 0; i < NUM_CHAN; i++) begin
                if (pending[i] && client_req[i].req && client_ack[i]) begin
                    client_req[i].req <= 1'b0;
                    assert (!tx_serial && prev_line)
                        else report_failure($sformatf(
                            "FAILED tx_serial: got 0x%0h prev 0x%0h at the ack edge",
                            tx_serial, prev_line));
                    if (n_acked == 0) begin
                        assert (chan_id_t'(i) == first)
                            else report_failure($sformatf("FAILED grant: got 0x%0h expected 0x%0h",
                                                          i, first));
                        assert (cyc - req_cyc - 1 == 2)
                            else report_failure($sformatf(
                                "FAILED client_ack latency: got 0x%0h expected 0x2",
                                cyc - req_cyc - 1));
                    end else begin
                        assert (saw_idle)
                            else report_failure("second channel acked before the frame ended");
                    end
                    n_acked++;
                end else if (pending[i] && !client_req[i].req && !client_ack[i]) begin
                    pending[i] = 1'b0;  // ack back to zero
                end
            end
            if (n_acked != 0 && !tx_busy) saw_idle = 1'b1;
            prev_line = tx_serial;
        end
        last_grant = (v.mask == 2'b11) ? ~first : first;
        while (exp_q.size() != 0) @(posedge clk);
        corrupt_on <= 1'b0;
    endtask

    initial begin
        int         fd;
        int         n;
        logic [1:0] m;
        uart_byte_t b0;
        uart_byte_t b1;
        logic       c;
        nRst       = 1'b0;
        client_req = '0;
        fd = $fopen("uart_link_vectors.txt", "r");
        assert (fd != 0) else report_failure("could not open uart_link_vectors.txt");
        n = $fscanf(fd, "%h %h %h %h\n", m, b0, b1, c);
        while (n == 4) begin
            vecs.push_back({m, b0, b1, c});
            n = $fscanf(fd, "%h %h %h %h\n", m, b0, b1, c);
        end
        $fclose(fd);
        assert (vecs.size() > 0) else report_failure("vector file holds no transfers");
        timeout_limit = vecs.size() * 2 * FRAME_CYCLES * 2 + 200;

        repeat (10) @(posedge clk);
        nRst <= 1'b1;
        repeat (5) begin
            @(posedge clk);
            assert (tx_serial)
                else report_failure($sformatf("FAILED tx_serial: got 0x%0h expected 0x1",
                                              tx_serial));
            assert (!tx_busy)
                else report_failure($sformatf("FAILED tx_busy: got 0x%0h expected 0x0",
                                              tx_busy));
            assert (client_ack == '0)
                else report_failure($sformatf("FAILED client_ack: got 0x%0h expected 0x0",
                                              client_ack));
        end

        foreach (vecs[i]) run_line(vecs[i]);
        repeat (2 * FRAME_CYCLES) @(posedge clk);   // room for a stray extra frame
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== uart_link.f ====
uart_pkg.sv
link_pkg.sv
tx_arbiter.sv
uart_tx.sv
uart_rx.sv
uart_link.sv
uart_link_props.sv
uart_link_tb.sv

// ==== Makefile ====
TOP = uart_link_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f uart_link.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f uart_link.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== uart_link_vectors.txt ====
1 a5 00 0
2 00 3c 0
1 01 00 0
2 00 80 1
3 55 aa 0
3 12 34 0
1 ff 00 0
3 0f f0 1
2 00 7e 0
1 c3 00 1
3 81 18 0
2 00 01 0
3 e7 7f 0
1 00 00 0
3 96 69 1
2 00 fe 0
1 b7 00 0
3 5a c4 0
2 00 33 1
1 7f 00 0
